// File: hw/mesi_config.svh
// Sizing macros for the MESI subsystem, included by the package and every RTL module
`ifndef MESI_CONFIG_SVH
`define MESI_CONFIG_SVH

`define MESI_ADDR_W    10   // Word address bits
`define MESI_DATA_W    32   // One word per line
`define MESI_CPUS      2    // Round-robin rule assumes two
`define MESI_SETS      16   // Direct-mapped sets per L1
`define MESI_MEM_WORDS 1024 // Flat main memory depth

`endif

// File: hw/mesi_pkg.sv
// Shared MESI types and link structs, referenced by scoped name from each RTL module
`include "mesi_config.svh"

package mesi_pkg;

    typedef logic [`MESI_ADDR_W-1:0] addr_t;                          // Word address
    typedef logic [`MESI_DATA_W-1:0] data_t;                          // Data word
    typedef logic [$clog2(`MESI_SETS)-1:0] index_t;                   // Low address bits
    typedef logic [`MESI_ADDR_W-$clog2(`MESI_SETS)-1:0] tag_t;        // Upper address bits

    typedef enum logic [1:0] {
        MODIFIED,
        EXCLUSIVE,
        SHARED,
        INVALID                                                       // Reset value
    } mesi_t;

    typedef enum logic [1:0] {
        BUS_RD,                                                       // Read for sharing
        BUS_RDX,                                                      // Read for ownership
        BUS_UPGR,                                                     // S to M, no data
        BUS_WB                                                        // Dirty victim out
    } bus_cmd_t;

    typedef struct packed {
        bus_cmd_t cmd;
        addr_t    addr;
        data_t    wdata;                                              // Victim data on BUS_WB
    } bus_req_t;                                                      // Unit to bus_ctrl

    typedef struct packed {
        data_t rdata;
        logic  exclusive;                                             // No other sharer
    } bus_resp_t;                                                     // bus_ctrl to unit

    typedef struct packed {
        addr_t addr;
        logic  inv;                                                   // Invalidate, else share
    } snoop_t;

    typedef struct packed {
        logic  hit;
        logic  dirty;                                                 // Data valid when set
        data_t data;
    } snoop_resp_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t wdata;
    } cpu_req_t;                                                      // L1 miss to unit

    typedef struct packed {
        data_t data;
        mesi_t state;
    } line_fill_t;                                                    // Unit to L1

endpackage

// File: hw/l1_cache.sv
// Private direct-mapped L1 with a Wishbone classic slave port and a snoop lookup port
`timescale 1ns/1ps
`include "mesi_config.svh"

module l1_cache #(
    parameter int CPU_ID = 0
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  mesi_pkg::addr_t         wb_adr,
    input  mesi_pkg::data_t         wb_dat_w,
    output mesi_pkg::data_t         wb_dat_r,
    output logic                    wb_ack,
    output logic                    miss_valid,
    output mesi_pkg::cpu_req_t      miss_req,
    output logic                    evict_valid,
    output mesi_pkg::addr_t         evict_addr,
    output mesi_pkg::data_t         evict_data,
    input  logic                    fill_done,
    input  mesi_pkg::line_fill_t    fill,
    input  logic                    snoop_lookup,
    input  mesi_pkg::index_t        snoop_index,
    output mesi_pkg::tag_t          snoop_tag,
    output mesi_pkg::mesi_t         snoop_state,
    output mesi_pkg::data_t         snoop_data,
    input  logic                    snoop_update,
    input  mesi_pkg::mesi_t         snoop_new_state
);

    typedef enum logic [1:0] {IDLE, LOOKUP, WAIT_FILL, ACK} l1_state_t;

    l1_state_t        state;
    mesi_pkg::tag_t   tag_arr   [`MESI_SETS];
    mesi_pkg::mesi_t  state_arr [`MESI_SETS];
    mesi_pkg::data_t  data_arr  [`MESI_SETS];
    mesi_pkg::tag_t   req_tag;
    mesi_pkg::index_t req_idx;
    logic             tag_hit;
    logic             local_ok;
    logic             snoop_busy;
    logic             hit_go;

    // Slot number must exist on the bus
    if (CPU_ID >= `MESI_CPUS) begin : g_id_check
        $error("l1_cache CPU_ID %0d exceeds CPU count", CPU_ID);
    end

    assign {req_tag, req_idx} = wb_adr;                              // Tag above index
    assign tag_hit    = (tag_arr[req_idx] == req_tag) &&
                        (state_arr[req_idx] != mesi_pkg::INVALID);
    assign local_ok   = tag_hit && (!wb_we || state_arr[req_idx] != mesi_pkg::SHARED);
    assign snoop_busy = snoop_lookup && (snoop_index == req_idx);    // Same set under snoop
    assign hit_go     = (state == LOOKUP) && !snoop_busy && local_ok;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            for (int i = 0; i < `MESI_SETS; i++) begin
                state_arr[i] <= mesi_pkg::INVALID;
            end
        end else begin
            case (state)
                IDLE:      if (wb_cyc && wb_stb) state <= LOOKUP;
                LOOKUP:    if (!snoop_busy) state <= local_ok ? ACK : WAIT_FILL;
                WAIT_FILL: if (fill_done) state <= ACK;
                default:   state <= IDLE;                            // ACK lasts one cycle
            endcase
            if (hit_go && wb_we) begin
                state_arr[req_idx] <= mesi_pkg::MODIFIED;            // Silent E to M
            end
            if (fill_done) begin
                state_arr[req_idx] <= fill.state;
            end
            if (snoop_update) begin
                state_arr[snoop_index] <= snoop_new_state;           // Downgrade or invalidate
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (hit_go) begin
            wb_dat_r <= wb_we ? wb_dat_w : data_arr[req_idx];
            if (wb_we) begin
                data_arr[req_idx] <= wb_dat_w;
            end
        end
        if (fill_done) begin
            tag_arr[req_idx]  <= req_tag;
            data_arr[req_idx] <= fill.data;                          // Write data already merged
            wb_dat_r          <= fill.data;
        end
    end

    assign wb_ack      = (state == ACK);
    assign miss_valid  = (state == WAIT_FILL);
    assign miss_req    = '{we: wb_we, addr: wb_adr, wdata: wb_dat_w};
    assign evict_valid = miss_valid && (state_arr[req_idx] == mesi_pkg::MODIFIED) &&
                         (tag_arr[req_idx] != req_tag);              // Dirty line displaced
    assign evict_addr  = {tag_arr[req_idx], req_idx};
    assign evict_data  = data_arr[req_idx];

    // Combinational snoop read
    assign snoop_tag   = tag_arr[snoop_index];
    assign snoop_state = snoop_lookup ? state_arr[snoop_index] : mesi_pkg::INVALID;
    assign snoop_data  = data_arr[snoop_index];

endmodule

// File: hw/coherency_unit.sv
// Per-CPU MESI controller turning L1 misses into bus transactions and answering snoops
`timescale 1ns/1ps
`include "mesi_config.svh"

module coherency_unit #(
    parameter int CPU_ID = 0
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    miss_valid,
    input  mesi_pkg::cpu_req_t      miss_req,
    input  logic                    evict_valid,
    input  mesi_pkg::addr_t         evict_addr,
    input  mesi_pkg::data_t         evict_data,
    output logic                    fill_done,
    output mesi_pkg::line_fill_t    fill,
    output logic                    snoop_lookup,
    output mesi_pkg::index_t        snoop_index,
    input  mesi_pkg::tag_t          snoop_tag,
    input  mesi_pkg::mesi_t         snoop_state,
    input  mesi_pkg::data_t         snoop_data,
    output logic                    snoop_update,
    output mesi_pkg::mesi_t         snoop_new_state,
    output logic                    bus_req_valid,
    output mesi_pkg::bus_req_t      bus_req,
    input  logic                    bus_done,
    input  mesi_pkg::bus_resp_t     bus_resp,
    input  logic                    snoop_valid,
    input  mesi_pkg::snoop_t        snoop,
    output logic                    snoop_done,
    output mesi_pkg::snoop_resp_t   snoop_resp
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE_BACK,
        READ_REQ,
        WRITE_REQ,
        RESP_CHKTAG,
        RESP_SEND
    } cu_state_t;

    cu_state_t             state;
    mesi_pkg::tag_t        miss_tag;
    mesi_pkg::index_t      miss_idx;
    mesi_pkg::tag_t        snp_tag;
    mesi_pkg::index_t      snp_idx;
    mesi_pkg::bus_req_t    req_q;
    mesi_pkg::snoop_resp_t snp_q;
    logic                  snp_hit;

    if (CPU_ID >= `MESI_CPUS) begin : g_id_check
        $error("coherency_unit CPU_ID %0d exceeds CPU count", CPU_ID);
    end

    assign {miss_tag, miss_idx} = miss_req.addr;
    assign {snp_tag, snp_idx}   = snoop.addr;
    assign snp_hit = (snoop_state != mesi_pkg::INVALID) && (snoop_tag == snp_tag);

    // Snoop preempts any waiting request, which is re-decided from IDLE
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (snoop_valid) begin
                        state <= RESP_CHKTAG;
                    end else if (evict_valid) begin
                        state <= WRITE_BACK;                         // Victim goes first
                    end else if (miss_valid) begin
                        state <= miss_req.we ? WRITE_REQ : READ_REQ;
                    end
                end
                WRITE_BACK, READ_REQ, WRITE_REQ: begin
                    if (snoop_valid) begin
                        state <= RESP_CHKTAG;
                    end else if (bus_done) begin
                        state <= IDLE;
                    end
                end
                RESP_CHKTAG: state <= RESP_SEND;
                default:     state <= IDLE;
            endcase
        end
    end

    // Request chosen from the line state seen in IDLE
    always_ff @(posedge CLK) begin
        if (state == IDLE && !snoop_valid) begin
            if (evict_valid) begin
                req_q <= '{cmd: mesi_pkg::BUS_WB, addr: evict_addr, wdata: evict_data};
            end else begin
                req_q.addr  <= miss_req.addr;
                req_q.wdata <= miss_req.wdata;
                if (!miss_req.we) begin
                    req_q.cmd <= mesi_pkg::BUS_RD;
                end else if (snoop_state == mesi_pkg::SHARED && snoop_tag == miss_tag) begin
                    req_q.cmd <= mesi_pkg::BUS_UPGR;                 // Copy still valid
                end else begin
                    req_q.cmd <= mesi_pkg::BUS_RDX;
                end
            end
        end
        if (state == RESP_CHKTAG) begin
            snp_q.hit   <= snp_hit;
            snp_q.dirty <= snp_hit && (snoop_state == mesi_pkg::MODIFIED);
            snp_q.data  <= snoop_data;
        end
    end

    always_comb begin
        snoop_lookup    = 1'b0;
        snoop_index     = miss_idx;
        snoop_update    = 1'b0;
        snoop_new_state = mesi_pkg::INVALID;
        fill_done       = 1'b0;
        fill            = '{data: miss_req.wdata, state: mesi_pkg::MODIFIED}; // Write result
        case (state)
            IDLE:       snoop_lookup = miss_valid;                  // Own line state
            WRITE_BACK: snoop_update = bus_done;                    // Victim now in memory
            READ_REQ: begin
                fill_done  = bus_done;
                fill.data  = bus_resp.rdata;
                fill.state = bus_resp.exclusive ? mesi_pkg::EXCLUSIVE : mesi_pkg::SHARED;
            end
            WRITE_REQ:  fill_done = bus_done;
            RESP_CHKTAG: begin
                snoop_lookup = 1'b1;
                snoop_index  = snp_idx;
            end
            RESP_SEND: begin
                snoop_lookup    = 1'b1;                             // Holds off local hits
                snoop_index     = snp_idx;
                snoop_update    = snp_q.hit;
                snoop_new_state = snoop.inv ? mesi_pkg::INVALID : mesi_pkg::SHARED;
            end
            default: ;
        endcase
    end

    assign bus_req_valid = (state inside {WRITE_BACK, READ_REQ, WRITE_REQ});
    assign bus_req       = req_q;
    assign snoop_done    = (state == RESP_SEND);
    assign snoop_resp    = snp_q;

endmodule

// File: hw/bus_ctrl.sv
// Snooping bus controller: round-robin grant, snoop broadcast and data routing to memory
`timescale 1ns/1ps
`include "mesi_config.svh"

module bus_ctrl (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    bus_req_valid [`MESI_CPUS],
    input  mesi_pkg::bus_req_t      bus_req       [`MESI_CPUS],
    output logic                    bus_done      [`MESI_CPUS],
    output mesi_pkg::bus_resp_t     bus_resp      [`MESI_CPUS],
    output logic                    snoop_valid   [`MESI_CPUS],
    output mesi_pkg::snoop_t        snoop         [`MESI_CPUS],
    input  logic                    snoop_done    [`MESI_CPUS],
    input  mesi_pkg::snoop_resp_t   snoop_resp    [`MESI_CPUS],
    output logic                    mem_req,
    output logic                    mem_we,
    output mesi_pkg::addr_t         mem_addr,
    output mesi_pkg::data_t         mem_wdata,
    input  logic                    mem_ack,
    input  mesi_pkg::data_t         mem_rdata
);

    localparam int SELW = $clog2(`MESI_CPUS);

    typedef enum logic [1:0] {ARB, SNOOP, MEM, DONE} bus_state_t;

    bus_state_t         state;
    logic [SELW-1:0]    owner;                                       // Granted CPU
    logic [SELW-1:0]    prio;                                        // Favored next
    logic [SELW-1:0]    pick;
    logic [SELW-1:0]    other;                                       // Snooped CPU
    logic               any_req;
    logic               wr_q;                                        // Memory write pending
    logic               excl_q;
    mesi_pkg::data_t    data_q;
    mesi_pkg::bus_req_t cur;

    assign other   = owner ^ SELW'(1);
    assign any_req = bus_req_valid[prio] || bus_req_valid[prio ^ SELW'(1)];
    assign pick    = bus_req_valid[prio] ? prio : prio ^ SELW'(1);
    assign cur     = bus_req[owner];                                 // Held until bus_done

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= ARB;
            owner <= '0;
            prio  <= '0;
            wr_q  <= 1'b0;
        end else begin
            case (state)
                ARB: begin
                    if (any_req) begin
                        owner <= pick;
                        prio  <= pick ^ SELW'(1);                    // Other CPU next time
                        wr_q  <= (bus_req[pick].cmd == mesi_pkg::BUS_WB);
                        state <= (bus_req[pick].cmd == mesi_pkg::BUS_WB) ? MEM : SNOOP;
                    end
                end
                SNOOP: begin
                    if (snoop_done[other]) begin
                        wr_q  <= snoop_resp[other].hit && snoop_resp[other].dirty; // Flush
                        state <= (cur.cmd == mesi_pkg::BUS_UPGR) ? DONE : MEM;
                    end
                end
                MEM:     if (mem_ack) state <= DONE;
                default: state <= ARB;
            endcase
        end
    end

    // Data path: victim, supplied or memory word
    always_ff @(posedge CLK) begin
        if (state == ARB && any_req) begin
            data_q <= bus_req[pick].wdata;
        end
        if (state == SNOOP && snoop_done[other]) begin
            data_q <= snoop_resp[other].data;
            excl_q <= !snoop_resp[other].hit;                        // No sharer left
        end
        if (state == MEM && mem_ack && !wr_q) begin
            data_q <= mem_rdata;
        end
    end

    always_comb begin
        for (int i = 0; i < `MESI_CPUS; i++) begin
            bus_done[i]    = (state == DONE) && (owner == SELW'(i));
            bus_resp[i]    = '{rdata: data_q, exclusive: excl_q};
            snoop_valid[i] = (state == SNOOP) && (owner != SELW'(i));
            snoop[i]       = '{addr: cur.addr, inv: cur.cmd != mesi_pkg::BUS_RD};
        end
    end

    assign mem_req   = (state == MEM);
    assign mem_we    = wr_q;
    assign mem_addr  = cur.addr;
    assign mem_wdata = data_q;

endmodule

// File: hw/main_memory.sv
// Flat word-addressed main memory behind the bus controller, one-cycle request handshake
`timescale 1ns/1ps
`include "mesi_config.svh"

module main_memory (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            mem_req,
    input  logic            mem_we,
    input  mesi_pkg::addr_t mem_addr,
    input  mesi_pkg::data_t mem_wdata,
    output logic            mem_ack,
    output mesi_pkg::data_t mem_rdata
);

    mesi_pkg::data_t mem_arr [`MESI_MEM_WORDS];

    initial begin
        for (int i = 0; i < `MESI_MEM_WORDS; i++) begin
            mem_arr[i] = '0;                                         // Memory starts zeroed
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= mem_req && !mem_ack;                          // One ack per request
        end
    end

    always_ff @(posedge CLK) begin
        if (mem_req && !mem_ack) begin
            if (mem_we) begin
                mem_arr[mem_addr] <= mem_wdata;
            end
            mem_rdata <= mem_arr[mem_addr];                          // Valid with ack
        end
    end

endmodule

// File: hw/mesi_top.sv
// Top level of the two-CPU MESI subsystem, one Wishbone port per CPU
`timescale 1ns/1ps
`include "mesi_config.svh"

module mesi_top (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            wb_cyc   [`MESI_CPUS],
    input  logic            wb_stb   [`MESI_CPUS],
    input  logic            wb_we    [`MESI_CPUS],
    input  mesi_pkg::addr_t wb_adr   [`MESI_CPUS],
    input  mesi_pkg::data_t wb_dat_w [`MESI_CPUS],
    output mesi_pkg::data_t wb_dat_r [`MESI_CPUS],
    output logic            wb_ack   [`MESI_CPUS]
);

    // L1 to unit links
    logic                  miss_valid      [`MESI_CPUS];
    mesi_pkg::cpu_req_t    miss_req        [`MESI_CPUS];
    logic                  evict_valid     [`MESI_CPUS];
    mesi_pkg::addr_t       evict_addr      [`MESI_CPUS];
    mesi_pkg::data_t       evict_data      [`MESI_CPUS];
    logic                  fill_done       [`MESI_CPUS];
    mesi_pkg::line_fill_t  fill            [`MESI_CPUS];
    logic                  snoop_lookup    [`MESI_CPUS];
    mesi_pkg::index_t      snoop_index     [`MESI_CPUS];
    mesi_pkg::tag_t        snoop_tag       [`MESI_CPUS];
    mesi_pkg::mesi_t       snoop_state     [`MESI_CPUS];
    mesi_pkg::data_t       snoop_data      [`MESI_CPUS];
    logic                  snoop_update    [`MESI_CPUS];
    mesi_pkg::mesi_t       snoop_new_state [`MESI_CPUS];
    // Unit to bus links
    logic                  bus_req_valid   [`MESI_CPUS];
    mesi_pkg::bus_req_t    bus_req         [`MESI_CPUS];
    logic                  bus_done        [`MESI_CPUS];
    mesi_pkg::bus_resp_t   bus_resp        [`MESI_CPUS];
    logic                  snoop_valid     [`MESI_CPUS];
    mesi_pkg::snoop_t      snoop           [`MESI_CPUS];
    logic                  snoop_done      [`MESI_CPUS];
    mesi_pkg::snoop_resp_t snoop_resp      [`MESI_CPUS];
    // Memory port
    logic                  mem_req;
    logic                  mem_we;
    mesi_pkg::addr_t       mem_addr;
    mesi_pkg::data_t       mem_wdata;
    logic                  mem_ack;
    mesi_pkg::data_t       mem_rdata;

    for (genvar i = 0; i < `MESI_CPUS; i++) begin : g_cpu
        l1_cache #(.CPU_ID(i)) l1_inst (
            .CLK(CLK), .nRST(nRST),
            .wb_cyc(wb_cyc[i]), .wb_stb(wb_stb[i]), .wb_we(wb_we[i]), .wb_adr(wb_adr[i]),
            .wb_dat_w(wb_dat_w[i]), .wb_dat_r(wb_dat_r[i]), .wb_ack(wb_ack[i]),
            .miss_valid(miss_valid[i]), .miss_req(miss_req[i]),
            .evict_valid(evict_valid[i]), .evict_addr(evict_addr[i]),
            .evict_data(evict_data[i]), .fill_done(fill_done[i]), .fill(fill[i]),
            .snoop_lookup(snoop_lookup[i]), .snoop_index(snoop_index[i]),
            .snoop_tag(snoop_tag[i]), .snoop_state(snoop_state[i]),
            .snoop_data(snoop_data[i]), .snoop_update(snoop_update[i]),
            .snoop_new_state(snoop_new_state[i])
        );

        coherency_unit #(.CPU_ID(i)) cu_inst (
            .CLK(CLK), .nRST(nRST),
            .miss_valid(miss_valid[i]), .miss_req(miss_req[i]),
            .evict_valid(evict_valid[i]), .evict_addr(evict_addr[i]),
            .evict_data(evict_data[i]), .fill_done(fill_done[i]), .fill(fill[i]),
            .snoop_lookup(snoop_lookup[i]), .snoop_index(snoop_index[i]),
            .snoop_tag(snoop_tag[i]), .snoop_state(snoop_state[i]),
            .snoop_data(snoop_data[i]), .snoop_update(snoop_update[i]),
            .snoop_new_state(snoop_new_state[i]),
            .bus_req_valid(bus_req_valid[i]), .bus_req(bus_req[i]),
            .bus_done(bus_done[i]), .bus_resp(bus_resp[i]),
            .snoop_valid(snoop_valid[i]), .snoop(snoop[i]),
            .snoop_done(snoop_done[i]), .snoop_resp(snoop_resp[i])
        );
    end

    bus_ctrl bus_ctrl_inst (.*);                                     // Names match one to one

    main_memory main_memory_inst (.*);

endmodule

// File: sim/mesi_asserts.sv
// Coherence and handshake checker, bound into mesi_top to watch both L1 state arrays
`timescale 1ns/1ps
`include "mesi_config.svh"

module mesi_asserts (
    input  logic            CLK,
    input  logic            nRST,
    input  mesi_pkg::mesi_t state0        [`MESI_SETS],
    input  mesi_pkg::mesi_t state1        [`MESI_SETS],
    input  mesi_pkg::tag_t  tag0          [`MESI_SETS],
    input  mesi_pkg::tag_t  tag1          [`MESI_SETS],
    input  logic            wb_ack        [`MESI_CPUS],
    input  logic            bus_req_valid [`MESI_CPUS],
    input  logic            bus_done      [`MESI_CPUS]
);

    int   violations = 0;                                            // Read by the testbench
    logic owner_clash;                                               // Both own the same line
    logic dirty_shared;                                              // M here, valid there

    always_comb begin
        owner_clash  = 1'b0;
        dirty_shared = 1'b0;
        for (int s = 0; s < `MESI_SETS; s++) begin
            if (state0[s] != mesi_pkg::INVALID && state1[s] != mesi_pkg::INVALID &&
                tag0[s] == tag1[s]) begin                            // Same word in both
                if (state0[s] inside {mesi_pkg::MODIFIED, mesi_pkg::EXCLUSIVE} &&
                    state1[s] inside {mesi_pkg::MODIFIED, mesi_pkg::EXCLUSIVE}) begin
                    owner_clash = 1'b1;
                end
                if (state0[s] == mesi_pkg::MODIFIED || state1[s] == mesi_pkg::MODIFIED) begin
                    dirty_shared = 1'b1;
                end
            end
        end
    end

    single_owner: assert property (@(posedge CLK) disable iff (!nRST) !owner_clash)
        else begin
            $error("Line held in M or E by both caches");
            violations++;
        end

    no_dirty_copy: assert property (@(posedge CLK) disable iff (!nRST) !dirty_shared)
        else begin
            $error("Modified line also valid in the other cache");
            violations++;
        end

    for (genvar i = 0; i < `MESI_CPUS; i++) begin : g_port
        ack_pulse: assert property (@(posedge CLK) disable iff (!nRST)
                                    wb_ack[i] |=> !wb_ack[i])
            else begin
                $error("wb_ack high for two cycles on CPU %0d", i);
                violations++;
            end

        done_after_req: assert property (@(posedge CLK) disable iff (!nRST)
                                         bus_done[i] |-> $past(bus_req_valid[i]))
            else begin
                $error("bus_done without a pending request on CPU %0d", i);
                violations++;
            end
    end

endmodule

bind mesi_top mesi_asserts mesi_asserts_inst (
    .CLK(CLK),
    .nRST(nRST),
    .state0(g_cpu[0].l1_inst.state_arr),
    .state1(g_cpu[1].l1_inst.state_arr),
    .tag0(g_cpu[0].l1_inst.tag_arr),
    .tag1(g_cpu[1].l1_inst.tag_arr),
    .wb_ack(wb_ack),
    .bus_req_valid(bus_req_valid),
    .bus_done(bus_done)
);

// File: sim/mesi_tb.sv
// Self-checking testbench for mesi_top, runs directed and random Wishbone traffic on both CPUs
`timescale 1ns/1ps
`include "mesi_config.svh"

module mesi_tb;

    localparam int          HALF_PERIOD    = 20;                     // 40 ns clock
    localparam int          RESET_CYCLES   = 8;
    localparam int          DIRECTED_TXNS  = 11;
    localparam int          RANDOM_TXNS    = 200;
    localparam int          TIMEOUT_CYCLES = 40 * (DIRECTED_TXNS + RANDOM_TXNS) + RESET_CYCLES;
    localparam logic [31:0] LFSR_SEED      = 32'hc6fa_68fc;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;          // x^32+x^22+x^2+x+1

    logic            CLK;
    logic            nRST;
    logic            wb_cyc     [`MESI_CPUS];
    logic            wb_stb     [`MESI_CPUS];
    logic            wb_we      [`MESI_CPUS];
    mesi_pkg::addr_t wb_adr     [`MESI_CPUS];
    mesi_pkg::data_t wb_dat_w   [`MESI_CPUS];
    mesi_pkg::data_t wb_dat_r   [`MESI_CPUS];
    logic            wb_ack     [`MESI_CPUS];
    mesi_pkg::data_t shadow     [`MESI_MEM_WORDS];                   // Last completed writes
    logic            rd_pending [`MESI_CPUS];                        // Read awaiting its ack
    mesi_pkg::addr_t rd_addr    [`MESI_CPUS];
    mesi_pkg::data_t rd_expect  [`MESI_CPUS];
    int              cycle_count;
    logic [31:0]     lfsr;

    mesi_top mesi_top_inst (
        .CLK(CLK),
        .nRST(nRST),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? LFSR_TAPS : 32'h0);        // Right-shift Galois
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    // Reference model: a read sees the last completed write
    function automatic mesi_pkg::data_t expected_read(input mesi_pkg::addr_t addr);
        return shadow[addr];
    endfunction

    function automatic mesi_pkg::cpu_req_t make_req(input logic we, input mesi_pkg::addr_t addr,
                                                    input mesi_pkg::data_t data);
        return '{we: we, addr: addr, wdata: data};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // One Wishbone classic cycle, cycles counts rising edges until ack
    task automatic wb_transfer(input int cpu, input mesi_pkg::cpu_req_t req, output int cycles);
        cycles = 0;
        @(posedge CLK);
        #2;
        wb_cyc[cpu]   = 1'b1;
        wb_stb[cpu]   = 1'b1;
        wb_we[cpu]    = req.we;
        wb_adr[cpu]   = req.addr;
        wb_dat_w[cpu] = req.wdata;
        if (!req.we) begin
            rd_addr[cpu]    = req.addr;
            rd_expect[cpu]  = expected_read(req.addr);               // Sequential traffic
            rd_pending[cpu] = 1'b1;
        end
        @(negedge CLK);
        while (!wb_ack[cpu]) begin
            cycles++;
            @(negedge CLK);
        end
        if (req.we) begin
            shadow[req.addr] = req.wdata;                            // Write done at ack
        end
        @(posedge CLK);
        #2;
        wb_cyc[cpu]     = 1'b0;
        wb_stb[cpu]     = 1'b0;
        rd_pending[cpu] = 1'b0;
    endtask

    // Compare process at the falling edge, outputs settled
    always @(negedge CLK) begin
        for (int i = 0; i < `MESI_CPUS; i++) begin
            if (wb_ack[i] && rd_pending[i]) begin
                assert (wb_dat_r[i] === rd_expect[i]) else begin
                    abort_run($sformatf("FAILED wb_dat_r[%0d] = %h, expected %h, addr %h",
                                        i, wb_dat_r[i], rd_expect[i], rd_addr[i]));
                end
            end
        end
        assert (mesi_top_inst.mesi_asserts_inst.violations == 0) else begin
            abort_run("A coherence assertion in the bound checker failed");
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_count++;
        end
        abort_run("Timeout: a Wishbone transaction was never acknowledged");
    end

    initial begin
        int              lat;
        logic [31:0]     bits;
        logic            rnd_we;
        mesi_pkg::addr_t rnd_addr;
        mesi_pkg::data_t rnd_data;
        nRST          = 1'b0;
        lfsr          = LFSR_SEED;
        for (int i = 0; i < `MESI_CPUS; i++) begin
            wb_cyc[i]     = 1'b0;
            wb_stb[i]     = 1'b0;
            wb_we[i]      = 1'b0;
            wb_adr[i]     = '0;
            wb_dat_w[i]   = '0;
            rd_pending[i] = 1'b0;
        end
        for (int a = 0; a < `MESI_MEM_WORDS; a++) begin
            shadow[a] = '0;                                          // Memory resets to zero
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        nRST = 1'b1;

        // Cold miss then a hit on the same word
        wb_transfer(0, make_req(1'b0, 10'h005, '0), lat);
        assert (lat >= 7) else begin
            abort_run($sformatf("Read miss acknowledged after only %0d cycles", lat));
        end
        wb_transfer(0, make_req(1'b0, 10'h005, '0), lat);
        assert (lat == 2) else begin
            abort_run($sformatf("Read hit acknowledged after %0d cycles instead of 2", lat));
        end

        // Dirty line in CPU 0 supplied to CPU 1
        wb_transfer(0, make_req(1'b1, 10'h023, 32'ha5a5_0023), lat);
        wb_transfer(1, make_req(1'b0, 10'h023, '0), lat);

        // Shared copy in CPU 0 invalidated by the upgrade in CPU 1
        wb_transfer(0, make_req(1'b0, 10'h031, '0), lat);
        wb_transfer(1, make_req(1'b0, 10'h031, '0), lat);
        wb_transfer(1, make_req(1'b1, 10'h031, 32'h5a5a_0031), lat);
        wb_transfer(0, make_req(1'b0, 10'h031, '0), lat);

        // Same set twice, victim goes back through memory
        wb_transfer(0, make_req(1'b1, 10'h047, 32'h0bad_0047), lat);
        wb_transfer(0, make_req(1'b1, 10'h057, 32'h0bad_0057), lat);
        wb_transfer(0, make_req(1'b0, 10'h047, '0), lat);

        // Random mix over 64 words, CPUs take turns
        for (int n = 0; n < RANDOM_TXNS; n++) begin
            draw_bits(1, bits);
            rnd_we = bits[0];
            draw_bits(6, bits);
            rnd_addr = mesi_pkg::addr_t'(bits[5:0]);
            draw_bits(32, bits);
            rnd_data = bits;
            wb_transfer(n % 2, make_req(rnd_we, rnd_addr, rnd_data), lat);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: build.f
+incdir+hw
hw/mesi_pkg.sv
hw/l1_cache.sv
hw/coherency_unit.sv
hw/bus_ctrl.sv
hw/main_memory.sv
hw/mesi_top.sv
sim/mesi_asserts.sv
sim/mesi_tb.sv
